// ==== Makefile ====
# Verilator build and run for the pin-multiplexing register core

VERILATOR ?= verilator
TOP       ?= tb_pinmux_top
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG  := TEST RESULT: FAIL
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || exit 1

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_pinmux_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pinmux_top
   import pinmux_reg_pkg::*, pinmux_pad_pkg::*;
();

   // Cycle bound for ack and irq waits
   localparam int TIMEOUT_CYC = 500;
   // Bound on register polls
   localparam int POLL_LIMIT  = 100;

   logic                mclk;
   logic                rst_n;
   logic                reg_cs;
   logic                reg_wr;
   logic [REG_AW-1:0]   reg_addr;
   logic [REG_DW-1:0]   reg_wdata;
   logic [REG_BEW-1:0]  reg_be;
   logic [REG_DW-1:0]   reg_rdata;
   logic                reg_ack;
   logic                irq;
   logic [NUM_PADS-1:0] pad_in;
   logic [NUM_PADS-1:0] pad_out;
   logic [NUM_PADS-1:0] pad_oen;

   integer              seed;
   // Phase flags for the concurrent checks
   logic                irq_must_stay_low;
   logic                tmr_pad_on;

   pinmux_top DUT (
      .mclk_i      (mclk),
      .rst_n_i     (rst_n),
      .reg_cs_i    (reg_cs),
      .reg_wr_i    (reg_wr),
      .reg_addr_i  (reg_addr),
      .reg_wdata_i (reg_wdata),
      .reg_be_i    (reg_be),
      .reg_rdata_o (reg_rdata),
      .reg_ack_o   (reg_ack),
      .irq_o       (irq),
      .pad_in_i    (pad_in),
      .pad_out_o   (pad_out),
      .pad_oen_o   (pad_oen)
   );

   // 4 ns clock
   always #2 mclk = ~mclk;

   // -------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
         else abort_run($sformatf("error: %s expected 0x%08h actual 0x%08h", name, exp, act));
   endtask

   // Block select and word offset on byte lane zero
   function automatic logic [REG_AW-1:0] reg_addr_of(input logic [2:0] sel,
                                                     input logic [REG_OW-1:0] offs);
      return {sel, offs, 2'b00};
   endfunction

   // Old word with enabled bytes taken from the new one
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] be);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8];
         end
      end
      return res;
   endfunction

   // Inputs change 1 ns past the rising edge
   task automatic next_cycle();
      @(posedge mclk);
      #1;
   endtask

   task automatic bus_access(input logic wr, input logic [REG_AW-1:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             output logic [31:0] rdata);
      int n;
      next_cycle();
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = addr;
      reg_wdata = wdata;
      reg_be    = be;
      n = 0;
      next_cycle();
      while (!reg_ack && n < TIMEOUT_CYC) begin
         next_cycle();
         n++;
      end
      if (!reg_ack) begin
         abort_run("bus access got no acknowledge before the timeout");
      end
      rdata = reg_rdata;
      // Chip select drops in the cycle after the ack
      next_cycle();
      reg_cs = 1'b0;
      reg_wr = 1'b0;
   endtask

   task automatic bus_write(input logic [REG_AW-1:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be);
      logic [31:0] unused;
      bus_access(1'b1, addr, wdata, be, unused);
   endtask

   task automatic bus_read(input logic [REG_AW-1:0] addr, output logic [31:0] rdata);
      bus_access(1'b0, addr, 32'h0, 4'hf, rdata);
   endtask

   // Read until the masked field matches and check it
   task automatic poll_until(input string name, input logic [REG_AW-1:0] addr,
                             input logic [31:0] mask, input logic [31:0] exp);
      logic [31:0] rd;
      int          n;
      n = 0;
      bus_read(addr, rd);
      while (((rd & mask) !== exp) && n < POLL_LIMIT) begin
         bus_read(addr, rd);
         n++;
      end
      check_eq(name, exp, rd & mask);
   endtask

   task automatic wait_irq(input logic level, input string name);
      int n;
      n = 0;
      while (irq !== level && n < TIMEOUT_CYC) begin
         next_cycle();
         n++;
      end
      check_eq(name, {31'b0, level}, {31'b0, irq});
   endtask

   // -------------------------------------------------------------------
   // Concurrent checks
   // -------------------------------------------------------------------
   a_ack_after_first_cs: assert property (@(posedge mclk) disable iff (!rst_n)
      reg_ack |-> ($past(reg_cs) && !$past(reg_cs, 2)))
      else abort_run("acknowledge came without a fresh chip select one cycle earlier");

   a_cs_gets_ack: assert property (@(posedge mclk) disable iff (!rst_n)
      ($past(reg_cs) && !$past(reg_cs, 2)) |-> reg_ack)
      else abort_run("chip select was not acknowledged in the following cycle");

   a_ack_single: assert property (@(posedge mclk) disable iff (!rst_n)
      $past(reg_ack) |-> !reg_ack)
      else abort_run("acknowledge lasted more than one cycle");

   a_irq_quiet: assert property (@(posedge mclk) disable iff (!rst_n)
      irq_must_stay_low |-> !irq)
      else abort_run("irq rose for an edge on a masked-out pad");

   a_tmr_pad_drives: assert property (@(posedge mclk) disable iff (!rst_n)
      tmr_pad_on |-> !pad_oen[TMR_WAVE_PAD0])
      else abort_run("timer pad stopped driving while in the timer function");

   // -------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------
   initial begin
      logic [31:0]         rnd;
      logic [31:0]         rd;
      logic [31:0]         model;
      logic [NUM_PADS-1:0] dir;
      logic [NUM_PADS-1:0] out;
      logic                wave_prev;
      logic                wave_now;
      int                  be_idx;

      mclk              = 1'b0;
      rst_n             = 1'b0;
      reg_cs            = 1'b0;
      reg_wr            = 1'b0;
      reg_addr          = '0;
      reg_wdata         = '0;
      reg_be            = '0;
      pad_in            = '0;
      irq_must_stay_low = 1'b0;
      tmr_pad_on        = 1'b0;
      seed              = 32'h6b67;

      repeat (16) @(posedge mclk);
      #1;
      rst_n = 1'b1;

      // Reset state with all pads as inputs
      check_eq("reset_irq", 32'h0, {31'b0, irq});
      check_eq("reset_ack", 32'h0, {31'b0, reg_ack});
      check_eq("reset_pad_oen", 32'h0000ffff, {16'h0, pad_oen});
      check_eq("reset_pad_out", 32'h0, {16'h0, pad_out});

      // Byte enables on the 16 bit GPIO_OUT
      model = 32'h0;
      for (be_idx = 0; be_idx < 16; be_idx++) begin
         rnd = $random(seed);
         bus_write(reg_addr_of(SEL_GPIO, GPIO_OUT), rnd, 4'(be_idx));
         model = merge_bytes(model, rnd, 4'(be_idx)) & 32'h0000ffff;
         bus_read(reg_addr_of(SEL_GPIO, GPIO_OUT), rd);
         check_eq($sformatf("byte_enable_%0h", be_idx), model, rd);
      end

      // Direction and output onto the pads
      rnd = $random(seed);
      dir = rnd[15:0];
      rnd = $random(seed);
      out = rnd[15:0];
      bus_write(reg_addr_of(SEL_GPIO, GPIO_DIR), {16'h0, dir}, 4'hf);
      bus_write(reg_addr_of(SEL_GPIO, GPIO_OUT), {16'h0, out}, 4'hf);
      next_cycle();
      check_eq("gpio_pad_oen", {16'h0, ~dir}, {16'h0, pad_oen});
      check_eq("gpio_pad_out", {16'h0, out & dir}, {16'h0, pad_out & dir});

      // Input path through the synchroniser
      rnd = $random(seed);
      pad_in = rnd[15:0];
      poll_until("gpio_in", reg_addr_of(SEL_GPIO, GPIO_IN), 32'h0000ffff, {16'h0, pad_in});

      // Quiet pads and clean status with pad 5 masked in
      pad_in = '0;
      poll_until("gpio_in_low", reg_addr_of(SEL_GPIO, GPIO_IN), 32'h0000ffff, 32'h0);
      bus_write(reg_addr_of(SEL_GPIO, GPIO_INTR_STAT), 32'h0000ffff, 4'hf);
      bus_write(reg_addr_of(SEL_GPIO, GPIO_INTR_MASK), 32'h00000020, 4'hf);
      bus_write(reg_addr_of(SEL_GLBL, GLBL_INTR_MASK), 32'h00000001, 4'hf);
      next_cycle();
      check_eq("irq_idle", 32'h0, {31'b0, irq});

      pad_in[5] = 1'b1;
      wait_irq(1'b1, "irq_gpio_edge");
      bus_write(reg_addr_of(SEL_GPIO, GPIO_INTR_STAT), 32'h00000020, 4'hf);
      wait_irq(1'b0, "irq_gpio_clear");

      // Edge on masked-out pad 9
      irq_must_stay_low = 1'b1;
      pad_in[9] = 1'b1;
      poll_until("gpio_stat_masked_out", reg_addr_of(SEL_GPIO, GPIO_INTR_STAT),
                 32'h00000200, 32'h00000200);
      bus_read(reg_addr_of(SEL_GLBL, GLBL_INTR_STAT), rd);
      check_eq("glbl_gpio_level", 32'h0, rd & 32'h1);
      irq_must_stay_low = 1'b0;
      bus_write(reg_addr_of(SEL_GPIO, GPIO_INTR_STAT), 32'h00000200, 4'hf);

      // Timer 0 on pad 0 with period (5+1)*(3+1) clocks
      bus_write(reg_addr_of(SEL_GLBL, GLBL_MULTI_FUNC), 32'h00000001, 4'hf);
      tmr_pad_on = 1'b1;
      bus_write(reg_addr_of(SEL_GLBL, GLBL_PRESCALE), 32'h00000003, 4'hf);
      bus_write(reg_addr_of(SEL_GLBL, GLBL_INTR_STAT), 32'h00000006, 4'hf);
      bus_write(reg_addr_of(SEL_TIMER, TMR0_CFG), 32'h00010005, 4'hf);

      // Waveform starts low and flips on each expiry
      wave_prev = 1'b0;
      for (be_idx = 0; be_idx < 3; be_idx++) begin
         poll_until($sformatf("timer_expiry_%0d", be_idx),
                    reg_addr_of(SEL_GLBL, GLBL_INTR_STAT), 32'h2, 32'h2);
         wave_now = pad_out[TMR_WAVE_PAD0];
         check_eq($sformatf("timer_wave_%0d", be_idx), {31'b0, ~wave_prev}, {31'b0, wave_now});
         check_eq("timer_pad_oen", 32'h0, {31'b0, pad_oen[TMR_WAVE_PAD0]});
         // Expected level after this expiry
         wave_prev = ~wave_prev;
         bus_write(reg_addr_of(SEL_GLBL, GLBL_INTR_STAT), 32'h00000002, 4'hf);
      end

      // Disabled timer stays silent over several periods
      bus_write(reg_addr_of(SEL_TIMER, TMR0_CFG), 32'h00000005, 4'hf);
      bus_write(reg_addr_of(SEL_GLBL, GLBL_INTR_STAT), 32'h00000002, 4'hf);
      for (be_idx = 0; be_idx < 40; be_idx++) begin
         bus_read(reg_addr_of(SEL_GLBL, GLBL_INTR_STAT), rd);
         check_eq("timer_off_quiet", 32'h0, rd & 32'h2);
      end

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/glbl_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module glbl_reg
   import pinmux_reg_pkg::*, pinmux_pad_pkg::*;
(
   input  logic                  mclk_i,
   input  logic                  rst_n_i,

   input  logic                  reg_cs_i,
   input  logic                  reg_wr_i,
   input  logic [REG_OW-1:0]     reg_offs_i,
   input  logic [REG_DW-1:0]     reg_wdata_i,
   input  logic [REG_BEW-1:0]    reg_be_i,
   output logic [REG_DW-1:0]     reg_rdata_o,
   output logic                  reg_ack_o,

   input  logic                  gpio_intr_i,
   input  logic [NUM_TIMERS-1:0] timer_expire_i,
   output logic                  irq_o,
   output logic [NUM_TIMERS-1:0] multi_func_o,
   output logic [TMR_CNT_W-1:0]  prescale_o
);

   logic                   reg_wr_stb;
   logic                   reg_rd_stb;
   logic [REG_DW-1:0]      be_mask;
   logic [REG_DW-1:0]      rdata_nxt;
   logic [NUM_TIMERS-1:0]  tmr_stat_q;
   logic [NUM_TIMERS-1:0]  tmr_stat_clr;
   logic [GLBL_INTR_W-1:0] intr_stat;
   logic [GLBL_INTR_W-1:0] intr_mask_q;
   logic [NUM_TIMERS-1:0]  multi_func_q;
   logic [TMR_CNT_W-1:0]   prescale_q;

   // First cycle of chip select only
   assign reg_wr_stb = reg_cs_i & reg_wr_i & ~reg_ack_o;
   assign reg_rd_stb = reg_cs_i & ~reg_wr_i & ~reg_ack_o;
   assign be_mask    = be_to_mask(reg_be_i);

   // GPIO level is live, timer bits are sticky
   assign intr_stat = {tmr_stat_q, gpio_intr_i};

   // Write one to clear, timer bits only
   assign tmr_stat_clr = (reg_wr_stb && reg_offs_i == GLBL_INTR_STAT) ?
                         reg_wdata_i[GLBL_INTR_W-1:1] & be_mask[GLBL_INTR_W-1:1] : '0;

   // -------------------------------------------------------------------
   // Control registers and interrupt
   // -------------------------------------------------------------------
   always_ff @(posedge mclk_i) begin
      if (!rst_n_i) begin
         reg_ack_o    <= 1'b0;
         irq_o        <= 1'b0;
         tmr_stat_q   <= '0;
         intr_mask_q  <= '0;
         multi_func_q <= '0;
         prescale_q   <= '0;
      end else begin
         reg_ack_o  <= reg_cs_i & ~reg_ack_o;
         // New expiry beats a clear in the same cycle
         tmr_stat_q <= (tmr_stat_q & ~tmr_stat_clr) | timer_expire_i;
         irq_o      <= |(intr_stat & intr_mask_q);
         if (reg_wr_stb) begin
            case (reg_offs_i)
               GLBL_INTR_MASK:
                  intr_mask_q <= (intr_mask_q & ~be_mask[GLBL_INTR_W-1:0]) |
                                 (reg_wdata_i[GLBL_INTR_W-1:0] & be_mask[GLBL_INTR_W-1:0]);
               GLBL_MULTI_FUNC:
                  multi_func_q <= (multi_func_q & ~be_mask[NUM_TIMERS-1:0]) |
                                  (reg_wdata_i[NUM_TIMERS-1:0] & be_mask[NUM_TIMERS-1:0]);
               GLBL_PRESCALE:
                  prescale_q <= (prescale_q & ~be_mask[TMR_CNT_W-1:0]) |
                                (reg_wdata_i[TMR_CNT_W-1:0] & be_mask[TMR_CNT_W-1:0]);
               default: ;
            endcase
         end
      end
   end

   // Read mux
   always_comb begin
      case (reg_offs_i)
         GLBL_INTR_STAT:  rdata_nxt = REG_DW'(intr_stat);
         GLBL_INTR_MASK:  rdata_nxt = REG_DW'(intr_mask_q);
         GLBL_MULTI_FUNC: rdata_nxt = REG_DW'(multi_func_q);
         GLBL_PRESCALE:   rdata_nxt = REG_DW'(prescale_q);
         default:         rdata_nxt = '0;
      endcase
   end

   // Captured with the ack edge
   always_ff @(posedge mclk_i) begin
      if (reg_rd_stb) begin
         reg_rdata_o <= rdata_nxt;
      end
   end

   assign multi_func_o = multi_func_q;
   assign prescale_o   = prescale_q;

   a_ack_after_cs: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
      reg_ack_o |-> $past(reg_cs_i) && !$past(reg_ack_o));

endmodule

`default_nettype wire

// ==== source/gpio_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_reg
   import pinmux_reg_pkg::*, pinmux_pad_pkg::*;
(
   input  logic                mclk_i,
   input  logic                rst_n_i,

   input  logic                reg_cs_i,
   input  logic                reg_wr_i,
   input  logic [REG_OW-1:0]   reg_offs_i,
   input  logic [REG_DW-1:0]   reg_wdata_i,
   input  logic [REG_BEW-1:0]  reg_be_i,
   output logic [REG_DW-1:0]   reg_rdata_o,
   output logic                reg_ack_o,

   input  logic [NUM_PADS-1:0] pad_sync_i,
   output logic [NUM_PADS-1:0] gpio_dir_o,
   output logic [NUM_PADS-1:0] gpio_out_o,
   output logic                gpio_intr_o
);

   logic                reg_wr_stb;
   logic                reg_rd_stb;
   logic [REG_DW-1:0]   be_mask;
   logic [NUM_PADS-1:0] wmask;
   logic [NUM_PADS-1:0] wdata;
   logic [REG_DW-1:0]   rdata_nxt;
   logic [NUM_PADS-1:0] dir_q;
   logic [NUM_PADS-1:0] out_q;
   logic [NUM_PADS-1:0] stat_q;
   logic [NUM_PADS-1:0] mask_q;
   logic [NUM_PADS-1:0] pad_prev_q;
   logic [NUM_PADS-1:0] pad_rise;
   logic [NUM_PADS-1:0] stat_clr;

   assign reg_wr_stb = reg_cs_i & reg_wr_i & ~reg_ack_o;
   assign reg_rd_stb = reg_cs_i & ~reg_wr_i & ~reg_ack_o;
   assign be_mask    = be_to_mask(reg_be_i);

   // Only the low bytes map onto pads
   assign wmask = be_mask[NUM_PADS-1:0];
   assign wdata = reg_wdata_i[NUM_PADS-1:0];

   // Rising edge against last sample, every pad
   assign pad_rise = pad_sync_i & ~pad_prev_q;

   assign stat_clr = (reg_wr_stb && reg_offs_i == GPIO_INTR_STAT) ? wdata & wmask : '0;

   // -------------------------------------------------------------------
   // Registers and edge capture
   // -------------------------------------------------------------------
   always_ff @(posedge mclk_i) begin
      if (!rst_n_i) begin
         reg_ack_o  <= 1'b0;
         dir_q      <= '0;
         out_q      <= '0;
         stat_q     <= '0;
         mask_q     <= '0;
         pad_prev_q <= '0;
      end else begin
         reg_ack_o  <= reg_cs_i & ~reg_ack_o;
         pad_prev_q <= pad_sync_i;
         // set wins over clear
         stat_q     <= (stat_q & ~stat_clr) | pad_rise;
         if (reg_wr_stb) begin
            case (reg_offs_i)
               GPIO_DIR:       dir_q  <= (dir_q & ~wmask) | (wdata & wmask);
               GPIO_OUT:       out_q  <= (out_q & ~wmask) | (wdata & wmask);
               GPIO_INTR_MASK: mask_q <= (mask_q & ~wmask) | (wdata & wmask);
               // Input and status handled elsewhere
               default: ;
            endcase
         end
      end
   end

   // Read mux
   always_comb begin
      case (reg_offs_i)
         GPIO_DIR:       rdata_nxt = REG_DW'(dir_q);
         GPIO_OUT:       rdata_nxt = REG_DW'(out_q);
         GPIO_IN:        rdata_nxt = REG_DW'(pad_sync_i);
         GPIO_INTR_STAT: rdata_nxt = REG_DW'(stat_q);
         GPIO_INTR_MASK: rdata_nxt = REG_DW'(mask_q);
         default:        rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge mclk_i) begin
      if (reg_rd_stb) begin
         reg_rdata_o <= rdata_nxt;
      end
   end

   assign gpio_dir_o  = dir_q;
   assign gpio_out_o  = out_q;
   // Level, held until software clears status
   assign gpio_intr_o = |(stat_q & mask_q);

endmodule

`default_nettype wire

// ==== source/pad_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module pad_mux
   import pinmux_pad_pkg::*;
(
   input  logic                  mclk_i,
   input  logic                  rst_n_i,

   input  logic [NUM_PADS-1:0]   pad_in_i,
   input  logic [NUM_PADS-1:0]   gpio_dir_i,
   input  logic [NUM_PADS-1:0]   gpio_out_i,
   input  logic [NUM_TIMERS-1:0] multi_func_i,
   input  logic [NUM_TIMERS-1:0] timer_wave_i,

   output logic [NUM_PADS-1:0]   pad_out_o,
   output logic [NUM_PADS-1:0]   pad_oen_o,
   output logic [NUM_PADS-1:0]   pad_sync_o
);

   logic [PAD_SYNC_STAGES-1:0][NUM_PADS-1:0] sync_q;

   // -------------------------------------------------------------------
   // Output side
   // -------------------------------------------------------------------
   always_comb begin
      // GPIO by default, dir 1 drives the pad
      pad_out_o = gpio_out_i;
      pad_oen_o = ~gpio_dir_i;
      // Timer function overrides its own pad
      for (int t = 0; t < NUM_TIMERS; t++) begin
         if (multi_func_i[t]) begin
            pad_out_o[TMR_WAVE_PAD0 + t] = timer_wave_i[t];
            pad_oen_o[TMR_WAVE_PAD0 + t] = 1'b0;
         end
      end
   end

   // Input synchroniser
   always_ff @(posedge mclk_i) begin
      if (!rst_n_i) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= pad_in_i;
         for (int s = 1; s < PAD_SYNC_STAGES; s++) begin
            sync_q[s] <= sync_q[s-1];
         end
      end
   end

   assign pad_sync_o = sync_q[PAD_SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== source/pinmux_pad_pkg.sv ====
`default_nettype none

package pinmux_pad_pkg;

   // Pads on the block boundary
   localparam int NUM_PADS = 16;

   // Timers, each with one waveform pad
   localparam int NUM_TIMERS = 2;

   // Flops in the pad input synchroniser
   localparam int PAD_SYNC_STAGES = 2;

   // Timer n lands on pad TMR_WAVE_PAD0 + n
   localparam int TMR_WAVE_PAD0 = 0;

endpackage

`default_nettype wire

// ==== source/pinmux_reg_pkg.sv ====
`default_nettype none

package pinmux_reg_pkg;

   // Bus widths
   localparam int REG_DW  = 32;
   localparam int REG_AW  = 9;
   localparam int REG_BEW = 4;
   // Word offset, address bits 5 to 2
   localparam int REG_OW  = 4;

   // Block select on address bits 8 to 6
   localparam logic [2:0] SEL_GLBL  = 3'd0;
   localparam logic [2:0] SEL_GPIO  = 3'd1;
   localparam logic [2:0] SEL_TIMER = 3'd2;

   // Global block word offsets
   localparam logic [REG_OW-1:0] GLBL_INTR_STAT  = 4'd0;
   localparam logic [REG_OW-1:0] GLBL_INTR_MASK  = 4'd1;
   localparam logic [REG_OW-1:0] GLBL_MULTI_FUNC = 4'd2;
   localparam logic [REG_OW-1:0] GLBL_PRESCALE   = 4'd3;
   // GPIO level in bit 0, timer expiries above it
   localparam int GLBL_INTR_W = 3;

   // GPIO block word offsets
   localparam logic [REG_OW-1:0] GPIO_DIR       = 4'd0;
   localparam logic [REG_OW-1:0] GPIO_OUT       = 4'd1;
   localparam logic [REG_OW-1:0] GPIO_IN        = 4'd2;
   localparam logic [REG_OW-1:0] GPIO_INTR_STAT = 4'd3;
   localparam logic [REG_OW-1:0] GPIO_INTR_MASK = 4'd4;

   // Timer block word offsets
   localparam logic [REG_OW-1:0] TMR0_CFG = 4'd0;
   localparam logic [REG_OW-1:0] TMR1_CFG = 4'd1;
   localparam logic [REG_OW-1:0] TMR0_CNT = 4'd2;
   localparam logic [REG_OW-1:0] TMR1_CNT = 4'd3;
   // Reload in low bits, enable just above
   localparam int TMR_CNT_W = 16;

   // Byte enables spread to a bit mask
   function automatic logic [REG_DW-1:0] be_to_mask(input logic [REG_BEW-1:0] be);
      logic [REG_DW-1:0] mask;
      for (int b = 0; b < REG_BEW; b++) begin
         mask[b*8 +: 8] = {8{be[b]}};
      end
      return mask;
   endfunction

endpackage

`default_nettype wire

// ==== source/pinmux_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_top
   import pinmux_reg_pkg::*, pinmux_pad_pkg::*;
(
   input  logic                mclk_i,
   input  logic                rst_n_i,

   // Register bus
   input  logic                reg_cs_i,
   input  logic                reg_wr_i,
   input  logic [REG_AW-1:0]   reg_addr_i,
   input  logic [REG_DW-1:0]   reg_wdata_i,
   input  logic [REG_BEW-1:0]  reg_be_i,
   output logic [REG_DW-1:0]   reg_rdata_o,
   output logic                reg_ack_o,

   output logic                irq_o,

   // Pads
   input  logic [NUM_PADS-1:0] pad_in_i,
   output logic [NUM_PADS-1:0] pad_out_o,
   output logic [NUM_PADS-1:0] pad_oen_o
);

   logic [2:0]             blk_sel;
   logic [REG_OW-1:0]      reg_offs;

   // Per block chip select and response
   logic                   glbl_cs;
   logic                   gpio_cs;
   logic                   timer_cs;
   logic [REG_DW-1:0]      glbl_rdata;
   logic [REG_DW-1:0]      gpio_rdata;
   logic [REG_DW-1:0]      timer_rdata;
   logic                   glbl_ack;
   logic                   gpio_ack;
   logic                   timer_ack;

   // Sideband between blocks
   logic                   gpio_intr;
   logic [NUM_TIMERS-1:0]  timer_expire;
   logic [NUM_TIMERS-1:0]  timer_wave;
   logic [NUM_TIMERS-1:0]  multi_func;
   logic [TMR_CNT_W-1:0]   prescale;
   logic [NUM_PADS-1:0]    gpio_dir;
   logic [NUM_PADS-1:0]    gpio_out;
   logic [NUM_PADS-1:0]    pad_sync;

   // -------------------------------------------------------------------
   // Block decode and response path
   // -------------------------------------------------------------------
   assign blk_sel  = reg_addr_i[8:6];
   assign reg_offs = reg_addr_i[5:2];

   assign glbl_cs  = reg_cs_i & (blk_sel == SEL_GLBL);
   assign gpio_cs  = reg_cs_i & (blk_sel == SEL_GPIO);
   assign timer_cs = reg_cs_i & (blk_sel == SEL_TIMER);

   // Unmapped selects stay silent, no ack ever
   always_comb begin
      case (blk_sel)
         SEL_GLBL: begin
            reg_rdata_o = glbl_rdata;
            reg_ack_o   = glbl_ack;
         end
         SEL_GPIO: begin
            reg_rdata_o = gpio_rdata;
            reg_ack_o   = gpio_ack;
         end
         SEL_TIMER: begin
            reg_rdata_o = timer_rdata;
            reg_ack_o   = timer_ack;
         end
         default: begin
            reg_rdata_o = '0;
            reg_ack_o   = 1'b0;
         end
      endcase
   end

   // -------------------------------------------------------------------
   // Register blocks
   // -------------------------------------------------------------------
   glbl_reg u_glbl_reg (
      .mclk_i         (mclk_i),
      .rst_n_i        (rst_n_i),
      .reg_cs_i       (glbl_cs),
      .reg_wr_i       (reg_wr_i),
      .reg_offs_i     (reg_offs),
      .reg_wdata_i    (reg_wdata_i),
      .reg_be_i       (reg_be_i),
      .reg_rdata_o    (glbl_rdata),
      .reg_ack_o      (glbl_ack),
      .gpio_intr_i    (gpio_intr),
      .timer_expire_i (timer_expire),
      .irq_o          (irq_o),
      .multi_func_o   (multi_func),
      .prescale_o     (prescale)
   );

   gpio_reg u_gpio_reg (
      .mclk_i         (mclk_i),
      .rst_n_i        (rst_n_i),
      .reg_cs_i       (gpio_cs),
      .reg_wr_i       (reg_wr_i),
      .reg_offs_i     (reg_offs),
      .reg_wdata_i    (reg_wdata_i),
      .reg_be_i       (reg_be_i),
      .reg_rdata_o    (gpio_rdata),
      .reg_ack_o      (gpio_ack),
      .pad_sync_i     (pad_sync),
      .gpio_dir_o     (gpio_dir),
      .gpio_out_o     (gpio_out),
      .gpio_intr_o    (gpio_intr)
   );

   timer_reg u_timer_reg (
      .mclk_i         (mclk_i),
      .rst_n_i        (rst_n_i),
      .reg_cs_i       (timer_cs),
      .reg_wr_i       (reg_wr_i),
      .reg_offs_i     (reg_offs),
      .reg_wdata_i    (reg_wdata_i),
      .reg_be_i       (reg_be_i),
      .reg_rdata_o    (timer_rdata),
      .reg_ack_o      (timer_ack),
      .prescale_i     (prescale),
      .timer_expire_o (timer_expire),
      .timer_wave_o   (timer_wave)
   );

   // Pad side
   pad_mux u_pad_mux (
      .mclk_i         (mclk_i),
      .rst_n_i        (rst_n_i),
      .pad_in_i       (pad_in_i),
      .gpio_dir_i     (gpio_dir),
      .gpio_out_i     (gpio_out),
      .multi_func_i   (multi_func),
      .timer_wave_i   (timer_wave),
      .pad_out_o      (pad_out_o),
      .pad_oen_o      (pad_oen_o),
      .pad_sync_o     (pad_sync)
   );

   // Blocks never answer together
   a_one_ack: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
      $onehot0({glbl_ack, gpio_ack, timer_ack}));

endmodule

`default_nettype wire

// ==== source/timer_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_reg
   import pinmux_reg_pkg::*, pinmux_pad_pkg::*;
(
   input  logic                  mclk_i,
   input  logic                  rst_n_i,

   input  logic                  reg_cs_i,
   input  logic                  reg_wr_i,
   input  logic [REG_OW-1:0]     reg_offs_i,
   input  logic [REG_DW-1:0]     reg_wdata_i,
   input  logic [REG_BEW-1:0]    reg_be_i,
   output logic [REG_DW-1:0]     reg_rdata_o,
   output logic                  reg_ack_o,

   input  logic [TMR_CNT_W-1:0]  prescale_i,
   output logic [NUM_TIMERS-1:0] timer_expire_o,
   output logic [NUM_TIMERS-1:0] timer_wave_o
);

   logic                                 reg_wr_stb;
   logic                                 reg_rd_stb;
   logic [REG_DW-1:0]                    be_mask;
   logic [TMR_CNT_W:0]                   wmask;
   logic [REG_DW-1:0]                    rdata_nxt;
   // Enable on top, reload below
   logic [NUM_TIMERS-1:0][TMR_CNT_W:0]   cfg_q;
   logic [NUM_TIMERS-1:0][TMR_CNT_W-1:0] cnt_q;
   logic [NUM_TIMERS-1:0]                tmr_en;
   logic [NUM_TIMERS-1:0]                expire_nxt;
   logic [TMR_CNT_W-1:0]                 psc_cnt_q;
   logic                                 tick;

   assign reg_wr_stb = reg_cs_i & reg_wr_i & ~reg_ack_o;
   assign reg_rd_stb = reg_cs_i & ~reg_wr_i & ~reg_ack_o;
   assign be_mask    = be_to_mask(reg_be_i);
   assign wmask      = be_mask[TMR_CNT_W:0];

   // Shared tick, every prescale + 1 clocks
   // >= covers prescale shrinking under a running count
   assign tick = (psc_cnt_q >= prescale_i);

   always_comb begin
      for (int i = 0; i < NUM_TIMERS; i++) begin
         tmr_en[i]     = cfg_q[i][TMR_CNT_W];
         expire_nxt[i] = tmr_en[i] & tick & (cnt_q[i] == '0);
      end
   end

   // -------------------------------------------------------------------
   // Config, prescaler and counters
   // -------------------------------------------------------------------
   always_ff @(posedge mclk_i) begin
      if (!rst_n_i) begin
         reg_ack_o      <= 1'b0;
         cfg_q          <= '0;
         cnt_q          <= '0;
         psc_cnt_q      <= '0;
         timer_expire_o <= '0;
         timer_wave_o   <= '0;
      end else begin
         reg_ack_o <= reg_cs_i & ~reg_ack_o;
         psc_cnt_q <= tick ? '0 : psc_cnt_q + 1'b1;
         if (reg_wr_stb && reg_offs_i == TMR0_CFG) begin
            cfg_q[0] <= (cfg_q[0] & ~wmask) | (reg_wdata_i[TMR_CNT_W:0] & wmask);
         end
         if (reg_wr_stb && reg_offs_i == TMR1_CFG) begin
            cfg_q[1] <= (cfg_q[1] & ~wmask) | (reg_wdata_i[TMR_CNT_W:0] & wmask);
         end
         for (int i = 0; i < NUM_TIMERS; i++) begin
            // Disabled timer parks at zero
            if (!tmr_en[i]) begin
               cnt_q[i] <= '0;
            end else if (tick) begin
               cnt_q[i] <= (cnt_q[i] == '0) ? cfg_q[i][TMR_CNT_W-1:0] : cnt_q[i] - 1'b1;
            end
         end
         timer_expire_o <= expire_nxt;
         timer_wave_o   <= timer_wave_o ^ expire_nxt;
      end
   end

   // Read mux, counts are read only
   always_comb begin
      case (reg_offs_i)
         TMR0_CFG: rdata_nxt = REG_DW'(cfg_q[0]);
         TMR1_CFG: rdata_nxt = REG_DW'(cfg_q[1]);
         TMR0_CNT: rdata_nxt = REG_DW'(cnt_q[0]);
         TMR1_CNT: rdata_nxt = REG_DW'(cnt_q[1]);
         default:  rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge mclk_i) begin
      if (reg_rd_stb) begin
         reg_rdata_o <= rdata_nxt;
      end
   end

   for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_tmr_chk
      a_no_expire_off: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
         timer_expire_o[i] |-> $past(tmr_en[i]));
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/pinmux_reg_pkg.sv
source/pinmux_pad_pkg.sv
source/pad_mux.sv
source/gpio_reg.sv
source/timer_reg.sv
source/glbl_reg.sv
source/pinmux_top.sv
dv/tb_pinmux_top.sv
